/* rtl/lite_pkg.sv */
package lite_pkg;

  // Bus widths
  localparam int WORD_W    = 16;
  localparam int WB_ADDR_W = 32;
  localparam int SEL_W     = 2;
  localparam int OPC_W     = 4;

  // Operand field in instruction bits 11 to 0, a halfword address
  localparam int OPER_W = 12;

  // Data word on both buses
  typedef logic [WORD_W-1:0] word_t;

  // Byte address on the Wishbone side
  typedef logic [WB_ADDR_W-1:0] wb_addr_t;

  // Halfword address on the core side, byte address without bit 0
  typedef logic [WB_ADDR_W-1:1] half_addr_t;

  // Byte lanes, bit 1 is the high byte
  typedef logic [SEL_W-1:0] sel_t;

  // First fetch after reset, as a byte address
  localparam wb_addr_t RESET_PC = '0;

  // Instruction opcodes in bits 15 to 12
  // Unlisted codes run as NOP
  typedef enum logic [OPC_W-1:0] {
    NOP = 4'd0,
    LD  = 4'd1,
    ADD = 4'd2,
    ST  = 4'd3,
    STL = 4'd4,
    STH = 4'd5,
    JMP = 4'd6
  } opcode_t;

  // Core bus request, all strobes active low
  typedef struct packed {
    half_addr_t addr;
    word_t      dout;
    logic       rd_n;
    logic       wr_n;
    logic       wr_h_n;
    logic       wr_l_n;
  } core_bus_t;

  // Bridge FSM
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    STRB = 2'd1,
    DONE = 2'd2
  } bridge_state_t;

  // Core FSM
  typedef enum logic [1:0] {
    FETCH    = 2'd0,
    EXEC     = 2'd1,
    HALTWAIT = 2'd2
  } core_state_t;

endpackage

/* rtl/lite_core.sv */
`timescale 1ns/10ps

module lite_core (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                wait_n_i,
  input  lite_pkg::word_t     din_i,
  output lite_pkg::core_bus_t cbus_o,
  output logic [7:0]          debug_o
);
  import lite_pkg::*;

  core_state_t       state_q;
  half_addr_t        pc_q;
  word_t             ir_q;
  word_t             acc_q;
  opcode_t           opcode;
  logic [OPER_W-1:0] operand;
  logic              mem_op;
  logic              req_active;
  logic              xfer_done;

  // Instruction fields
  assign opcode  = opcode_t'(ir_q[15:12]);
  assign operand = ir_q[OPER_W-1:0];

  // Opcodes that need a data transaction in EXEC
  always_comb begin
    case (opcode)
      LD, ADD, ST, STL, STH: mem_op = 1'b1;
      default:               mem_op = 1'b0;
    endcase
  end

  // Bus request built from registered state only
  always_comb begin
    cbus_o.addr   = pc_q;
    cbus_o.dout   = acc_q;
    cbus_o.rd_n   = 1'b1;
    cbus_o.wr_n   = 1'b1;
    cbus_o.wr_h_n = 1'b1;
    cbus_o.wr_l_n = 1'b1;
    case (state_q)
      FETCH: begin
        // Instruction read at the PC
        cbus_o.rd_n = 1'b0;
      end
      EXEC: begin
        // Operand is already a halfword address
        cbus_o.addr = half_addr_t'(operand);
        case (opcode)
          LD, ADD: begin
            cbus_o.rd_n = 1'b0;
          end
          ST: begin
            cbus_o.wr_n   = 1'b0;
            cbus_o.wr_h_n = 1'b0;
            cbus_o.wr_l_n = 1'b0;
          end
          STL: begin
            // Low byte on both lanes, only the low lane is written
            cbus_o.dout   = {acc_q[7:0], acc_q[7:0]};
            cbus_o.wr_n   = 1'b0;
            cbus_o.wr_l_n = 1'b0;
          end
          STH: begin
            // Same byte, high lane enabled instead
            cbus_o.dout   = {acc_q[7:0], acc_q[7:0]};
            cbus_o.wr_n   = 1'b0;
            cbus_o.wr_h_n = 1'b0;
          end
          default: begin
            // JMP and NOP stay off the bus
          end
        endcase
      end
      default: begin
        // Idle cycle after reset, no request
      end
    endcase
  end

  assign req_active = ~cbus_o.rd_n | ~cbus_o.wr_n;

  // Transfer finishes in the first active cycle with wait released
  assign xfer_done = req_active & wait_n_i;

  // Instruction register, loaded when a fetch completes
  always_ff @(posedge clk_i) begin
    if (state_q == FETCH && xfer_done) begin
      ir_q <= din_i;
    end
  end

  // Control FSM, PC and accumulator
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= HALTWAIT;
      pc_q    <= half_addr_t'(RESET_PC >> 1);
      acc_q   <= '0;
    end else begin
      case (state_q)
        HALTWAIT: begin
          // One quiet cycle before the first fetch
          state_q <= FETCH;
        end
        FETCH: begin
          if (xfer_done) begin
            state_q <= EXEC;
          end
        end
        EXEC: begin
          if (opcode == JMP) begin
            pc_q    <= half_addr_t'(operand);
            state_q <= FETCH;
          end else if (!mem_op) begin
            pc_q    <= pc_q + 1'b1;
            state_q <= FETCH;
          end else if (xfer_done) begin
            // Data transfer finished, next instruction
            pc_q    <= pc_q + 1'b1;
            state_q <= FETCH;
            if (opcode == LD) begin
              acc_q <= din_i;
            end else if (opcode == ADD) begin
              acc_q <= acc_q + din_i;
            end
          end
        end
        default: begin
          state_q <= HALTWAIT;
        end
      endcase
    end
  end

  assign debug_o = acc_q[7:0];

  // Read and write strobes are exclusive
  a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(!cbus_o.rd_n && !cbus_o.wr_n))
    else $error("core drives rd_n and wr_n low together");

  // Request held while the bridge stalls
  a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_active && !wait_n_i) |=> $stable(cbus_o))
    else $error("core request changed during a stall");

endmodule

/* rtl/lite_wb_bridge.sv */
`timescale 1ns/10ps

module lite_wb_bridge (
  input  logic                clk_i,
  input  logic                rst_i,
  input  lite_pkg::core_bus_t cbus_i,
  output lite_pkg::word_t     cpu_din_o,
  output logic                wait_n_o,
  input  lite_pkg::word_t     wb_dat_i,
  input  logic                wb_ack_i,
  output lite_pkg::word_t     wb_dat_o,
  output lite_pkg::wb_addr_t  wb_adr_o,
  output lite_pkg::sel_t      wb_sel_o,
  output logic                wb_we_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o
);
  import lite_pkg::*;

  bridge_state_t state_q;
  bridge_state_t state_d;
  logic          rd_req;
  logic          wr_req;
  logic          cpu_req;
  word_t         rdata_q;

  // Valid request decode from the active-low strobes
  assign rd_req  = ~cbus_i.rd_n;
  assign wr_req  = ~cbus_i.wr_n & (~cbus_i.wr_h_n | ~cbus_i.wr_l_n);
  assign cpu_req = rd_req | wr_req;

  // Address, data and lanes map straight across
  assign wb_adr_o = {cbus_i.addr, 1'b0};
  assign wb_dat_o = cbus_i.dout;
  assign wb_we_o  = ~cbus_i.wr_n;
  assign wb_sel_o = cbus_i.wr_n ? sel_t'(2'b11) : {~cbus_i.wr_h_n, ~cbus_i.wr_l_n};

  // Strobe drops for the DONE cycle so each request gives one cycle
  assign wb_stb_o = cpu_req & (state_q != DONE);
  assign wb_cyc_o = wb_stb_o;

  // Core stalls until the registered result is ready
  assign wait_n_o  = (state_q == DONE) | ~cpu_req;
  assign cpu_din_o = rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Zero-wait slaves may ack in the first strobe cycle
        if (cpu_req) begin
          state_d = wb_ack_i ? DONE : STRB;
        end
      end
      STRB: begin
        if (wb_ack_i) begin
          state_d = DONE;
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture read data on ack
  always_ff @(posedge clk_i) begin
    if (wb_ack_i && wb_stb_o) begin
      rdata_q <= wb_dat_i;
    end
  end

  // Every ack is followed by DONE with strobe low
  a_done_after_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    (wb_ack_i && wb_stb_o) |=> (state_q == DONE && !wb_stb_o))
    else $error("bridge strobe not released after ack");

  // Slave must not ack without a strobe
  a_ack_with_stb: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_i |-> wb_stb_o)
    else $error("wb_ack_i seen while wb_stb_o is low");

endmodule

/* rtl/lite_wb_top.sv */
`timescale 1ns/10ps

module lite_wb_top (
  input  logic               clk_i,
  input  logic               rst_i,
  input  lite_pkg::word_t    wb_dat_i,
  input  logic               wb_ack_i,
  output lite_pkg::word_t    wb_dat_o,
  output lite_pkg::wb_addr_t wb_adr_o,
  output lite_pkg::sel_t     wb_sel_o,
  output logic               wb_we_o,
  output logic               wb_cyc_o,
  output logic               wb_stb_o,
  output logic [7:0]         debug_o
);
  import lite_pkg::*;

  // Core bus between the two blocks
  core_bus_t cbus;
  word_t     cpu_din;
  logic      cpu_wait_n;

  lite_core lite_core_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wait_n_i (cpu_wait_n),
    .din_i    (cpu_din),
    .cbus_o   (cbus),
    .debug_o  (debug_o)
  );

  lite_wb_bridge lite_wb_bridge_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .cbus_i    (cbus),
    .cpu_din_o (cpu_din),
    .wait_n_o  (cpu_wait_n),
    .wb_dat_i  (wb_dat_i),
    .wb_ack_i  (wb_ack_i),
    .wb_dat_o  (wb_dat_o),
    .wb_adr_o  (wb_adr_o),
    .wb_sel_o  (wb_sel_o),
    .wb_we_o   (wb_we_o),
    .wb_cyc_o  (wb_cyc_o),
    .wb_stb_o  (wb_stb_o)
  );

endmodule

/* verif/tb_lite_wb.sv */
`timescale 1ns/10ps

module tb_lite_wb;
  import lite_pkg::*;

  localparam int MEM_WORDS  = 4096;
  localparam int PROG_WORDS = 256;
  localparam int DATA_BASE  = 2048;
  localparam int DATA_WORDS = 256;
  localparam int N_INSTR    = 400;
  localparam int TIMEOUT    = 200;

  logic     clk_i;
  logic     rst_i;
  word_t    wb_dat_i;
  logic     wb_ack_i;
  word_t    wb_dat_o;
  wb_addr_t wb_adr_o;
  sel_t     wb_sel_o;
  logic     wb_we_o;
  logic     wb_cyc_o;
  logic     wb_stb_o;
  logic [7:0] debug_o;

  // Memory seen by the DUT and the memory the model expects
  logic [15:0] slave_mem [0:MEM_WORDS-1];
  logic [15:0] model_mem [0:MEM_WORDS-1];

  int unsigned rng_state;
  int          errors;
  int          checks;
  logic        timed_out;
  logic        fast_acks;

  lite_wb_top lite_wb_top_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i),
    .wb_dat_o (wb_dat_o),
    .wb_adr_o (wb_adr_o),
    .wb_sel_o (wb_sel_o),
    .wb_we_o  (wb_we_o),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .debug_o  (debug_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // LCG with the upper bits as output
  function automatic int unsigned next_random();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return (rng_state >> 16) & 32'h7fff;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  // Bus quiet and accumulator cleared
  task automatic check_idle();
    check_eq("wb_stb_o", 32'd0, 32'(wb_stb_o));
    check_eq("wb_cyc_o", 32'd0, 32'(wb_cyc_o));
    check_eq("wb_we_o", 32'd0, 32'(wb_we_o));
    check_eq("debug_o", 32'd0, 32'(debug_o));
  endtask

  // Request seen on the bus against the predicted one
  task automatic check_req(input wb_addr_t adr, input logic we, input sel_t sel,
                           input word_t dat);
    word_t mask;
    mask = {{8{sel[1]}}, {8{sel[0]}}};
    check_eq("wb_stb_o", 32'd1, 32'(wb_stb_o));
    check_eq("wb_cyc_o", 32'd1, 32'(wb_cyc_o));
    check_eq("wb_adr_o", adr, wb_adr_o);
    check_eq("wb_we_o", 32'(we), 32'(wb_we_o));
    check_eq("wb_sel_o", 32'(sel), 32'(wb_sel_o));
    // Only the enabled lanes matter on a write
    if (we) begin
      check_eq("wb_dat_o", 32'(dat & mask), 32'(wb_dat_o & mask));
    end
  endtask

  // Strobe polled just after each rising edge
  task automatic wait_for_stb();
    int count;
    count = 0;
    while (!timed_out) begin
      @(posedge clk_i);
      #1;
      if (wb_stb_o) begin
        break;
      end
      count++;
      if (count >= TIMEOUT) begin
        errors++;
        timed_out = 1'b1;
        $display("Timeout: no Wishbone strobe within %0d cycles", TIMEOUT);
      end
    end
  endtask

  // One Wishbone cycle as the slave, checked against the prediction
  task automatic do_xfer(input wb_addr_t adr, input logic we, input sel_t sel,
                         input word_t dat, output word_t rdata);
    int          waits;
    int          idx;
    logic        wr;
    sel_t        wsel;
    word_t       wdat;
    rdata = '0;
    wait_for_stb();
    if (timed_out) begin
      return;
    end
    check_req(adr, we, sel, dat);
    idx   = int'(wb_adr_o[12:1]);
    wr    = wb_we_o;
    wsel  = wb_sel_o;
    wdat  = wb_dat_o;
    waits = fast_acks ? 0 : int'(next_random() % 4);
    // Request must stay put through the wait states
    repeat (waits) begin
      @(posedge clk_i);
      #1;
      check_req(adr, we, sel, dat);
    end
    // Zero waits acks in the first strobe cycle
    wb_ack_i = 1'b1;
    if (wr) begin
      if (wsel[0]) slave_mem[idx][7:0] = wdat[7:0];
      if (wsel[1]) slave_mem[idx][15:8] = wdat[15:8];
      wb_dat_i = '0;
    end else begin
      wb_dat_i = slave_mem[idx];
      rdata    = slave_mem[idx];
    end
    @(posedge clk_i);
    #1;
    wb_ack_i = 1'b0;
    // Bridge DONE cycle
    check_eq("wb_stb_o after ack", 32'd0, 32'(wb_stb_o));
  endtask

  initial begin
    int          pc;
    int          n;
    int          oper;
    logic [3:0]  op;
    word_t       acc;
    word_t       instr;
    word_t       rdata;
    wb_addr_t    dadr;

    rst_i     = 1'b1;
    wb_ack_i  = 1'b0;
    wb_dat_i  = '0;
    rng_state = 37;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    fast_acks = 1'b0;

    // Background pattern from the full word index
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = 16'(i) ^ 16'h5a5a;
    end
    // Random program with data operands in the data region
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
      op = 4'(next_random() % 7);
      if (op == JMP) oper = int'(next_random() % (PROG_WORDS - 1));
      else if (op == NOP) oper = int'(next_random() % MEM_WORDS);
      else oper = DATA_BASE + int'(next_random() % DATA_WORDS);
      model_mem[i] = {op, 12'(oper)};
    end
    // Program ends in a jump to itself
    model_mem[PROG_WORDS-1] = {4'(JMP), 12'(PROG_WORDS - 1)};
    for (int i = DATA_BASE; i < DATA_BASE + DATA_WORDS; i++) begin
      model_mem[i] = 16'(next_random() ^ (next_random() << 1));
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      slave_mem[i] = model_mem[i];
    end

    // Three clock edges under reset and one idle cycle
    repeat (2) begin
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_idle();

    pc  = 0;
    acc = '0;
    for (n = 0; n < N_INSTR && !timed_out; n++) begin
      // Stretch of zero-wait acks in the middle
      fast_acks = (n >= 200 && n < 260);
      instr = model_mem[pc];
      do_xfer(32'(pc * 2), 1'b0, 2'b11, '0, rdata);
      if (timed_out) break;
      check_eq("fetch word", 32'(instr), 32'(rdata));
      check_eq("debug_o", 32'(acc[7:0]), 32'(debug_o));
      op   = instr[15:12];
      oper = int'(instr[11:0]);
      dadr = 32'(oper * 2);
      case (op)
        LD, ADD: begin
          do_xfer(dadr, 1'b0, 2'b11, '0, rdata);
          check_eq("read data", 32'(model_mem[oper]), 32'(rdata));
          if (op == LD) acc = model_mem[oper];
          else acc = acc + model_mem[oper];
        end
        ST: begin
          do_xfer(dadr, 1'b1, 2'b11, acc, rdata);
          model_mem[oper] = acc;
        end
        STL: begin
          do_xfer(dadr, 1'b1, 2'b01, {acc[7:0], acc[7:0]}, rdata);
          model_mem[oper][7:0] = acc[7:0];
        end
        STH: begin
          do_xfer(dadr, 1'b1, 2'b10, {acc[7:0], acc[7:0]}, rdata);
          model_mem[oper][15:8] = acc[7:0];
        end
        default: begin
          // JMP and NOP have no data cycle
        end
      endcase
      pc = (op == JMP) ? oper : pc + 1;
    end

    // Accumulator after the last instruction
    if (!timed_out) begin
      @(posedge clk_i);
      #1;
      check_eq("debug_o", 32'(acc[7:0]), 32'(debug_o));
    end

    $display("Run finished: %0d instructions, %0d checks, %0d errors", n, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* files.f */
rtl/lite_pkg.sv
rtl/lite_core.sv
rtl/lite_wb_bridge.sv
rtl/lite_wb_top.sv
verif/tb_lite_wb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the Wishbone bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/10ps \
  --top-module tb_lite_wb \
  --Mdir obj_dir -o sim_lite_wb \
  -f files.f

./obj_dir/sim_lite_wb | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
  exit 1
fi
exit 0
